// File: include/exec_settings.svh
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// Datapath widths
`define XLEN 32
`define ALEN 32

// Trap cause codes
`define EXC_INSTR_ADDR_MISALIGNED 4'd0
`define EXC_ILLEGAL_INSTR 4'd2

`endif

// File: verilog/exec_pkg.sv
`include "exec_settings.svh"

package exec_pkg;

    typedef enum logic [4:0] {
        OP_IMM = 5'b00100,
        OP     = 5'b01100,
        LUI    = 5'b01101,
        BRANCH = 5'b11000,
        JALR   = 5'b11001,
        JAL    = 5'b11011
    } opcode_e;

    typedef enum logic [3:0] {
        EXC_INSTR_ADDR_MISALIGNED = `EXC_INSTR_ADDR_MISALIGNED,
        EXC_ILLEGAL_INSTR         = `EXC_ILLEGAL_INSTR
    } trap_cause_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [4:0] opcode;
        logic [1:0] quadrant; // 2'b11 for 32-bit encodings
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [4:0]  opcode;
        logic [1:0]  quadrant;
    } i_fmt_t;

    typedef struct packed {
        logic        imm_12;
        logic [5:0]  imm_10_5;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [3:0]  imm_4_1;
        logic        imm_11;
        logic [4:0]  opcode;
        logic [1:0]  quadrant;
    } b_fmt_t;

    typedef struct packed {
        logic        imm_20;
        logic [9:0]  imm_10_1;
        logic        imm_11;
        logic [7:0]  imm_19_12;
        logic [4:0]  rd;
        logic [4:0]  opcode;
        logic [1:0]  quadrant;
    } j_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [4:0]  opcode;
        logic [1:0]  quadrant;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
        u_fmt_t u_fmt;
    } instr_u;

    typedef struct packed {
        logic              valid;
        instr_u            instr;
        logic [`ALEN-1:0]  pc;
        logic [`XLEN-1:0]  rs1_data;
        logic [`XLEN-1:0]  rs2_data;
    } exec_in_t;

    typedef struct packed {
        opcode_e           opcode;
        logic [2:0]        funct3;
        logic              funct7_alt; // Instruction bit 30
        logic [4:0]        rd;
        logic [`XLEN-1:0]  imm;
        logic [`ALEN-1:0]  next_pc;
        logic              is_branch;
        logic              is_alu;
        logic              is_illegal;
    } decoded_t;

    typedef struct packed {
        logic              valid;
        logic              exception;
        trap_cause_e       trap_cause;
        logic [4:0]        rd;
        logic              wr_en;
        logic [`XLEN-1:0]  data;
    } exec_result_t;

    typedef struct packed {
        logic              valid;
        logic [`ALEN-1:0]  pc;
    } redirect_t;

endpackage

// File: verilog/instr_decode.sv
`timescale 1ns/1ps
`include "exec_settings.svh"

module instr_decode
    import exec_pkg::*;
(
    input  instr_u            instr,
    input  logic [`ALEN-1:0]  pc,
    output decoded_t          dec
);

    opcode_e opcode;
    logic    enc_ok;

    assign opcode = opcode_e'(instr.r_fmt.opcode);
    assign enc_ok = instr.r_fmt.quadrant == 2'b11; // No compressed support

    always_comb begin
        dec.opcode     = opcode;
        dec.funct3     = instr.r_fmt.funct3;
        dec.funct7_alt = instr.r_fmt.funct7[5];
        dec.rd         = instr.r_fmt.rd;
        dec.next_pc    = pc + `ALEN'(4);

        case (opcode)
            OP_IMM, JALR: begin
                dec.imm = {{(`XLEN-12){instr.i_fmt.imm_11_0[11]}},
                           instr.i_fmt.imm_11_0};
            end
            BRANCH: begin
                dec.imm = {{(`XLEN-13){instr.b_fmt.imm_12}},
                           instr.b_fmt.imm_12,
                           instr.b_fmt.imm_11,
                           instr.b_fmt.imm_10_5,
                           instr.b_fmt.imm_4_1,
                           1'b0};
            end
            JAL: begin
                dec.imm = {{(`XLEN-21){instr.j_fmt.imm_20}},
                           instr.j_fmt.imm_20,
                           instr.j_fmt.imm_19_12,
                           instr.j_fmt.imm_11,
                           instr.j_fmt.imm_10_1,
                           1'b0};
            end
            LUI: begin
                dec.imm = {instr.u_fmt.imm_31_12, 12'b0};
            end
            default: begin
                dec.imm = '0; // R-type and unknown
            end
        endcase

        case (opcode)
            JAL, JALR, BRANCH: begin
                dec.is_branch = enc_ok;
                dec.is_alu    = 1'b0;
            end
            OP, OP_IMM, LUI: begin
                dec.is_branch = 1'b0;
                dec.is_alu    = enc_ok;
            end
            default: begin
                dec.is_branch = 1'b0;
                dec.is_alu    = 1'b0;
            end
        endcase

        // Anything unclaimed goes to the ALU as illegal
        dec.is_illegal = !(dec.is_branch || dec.is_alu);
    end

endmodule

// File: verilog/exec_branch.sv
`timescale 1ns/1ps
`include "exec_settings.svh"

module exec_branch
    import exec_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  decoded_t          dec,
    input  logic [`ALEN-1:0]  pc,
    input  logic [`XLEN-1:0]  rs1_data,
    input  logic [`XLEN-1:0]  rs2_data,
    input  logic              req_valid,
    input  logic              accept,
    output exec_result_t      result,
    output redirect_t         redirect
);

    logic [`ALEN-1:0] adder_base;
    logic [`ALEN-1:0] adder_sum;
    logic [`ALEN-1:0] target;
    logic             illegal;
    logic             misaligned;
    logic             cond_taken;
    logic             fire;

    logic             taken_q;
    logic [`ALEN-1:0] saved_target;

    logic             cmp_eq;
    logic             cmp_lt;
    logic             cmp_ltu;

    assign fire = accept && dec.is_branch;

    assign adder_base = (dec.opcode == JALR) ? rs1_data : pc;
    assign adder_sum  = adder_base + dec.imm;

    always_comb begin
        target  = adder_sum;
        illegal = 1'b0;
        case (dec.opcode)
            JALR: begin
                target  = {adder_sum[`ALEN-1:1], 1'b0}; // LSB dropped per spec
                illegal = dec.funct3 != 3'b000;
            end
            BRANCH: begin
                illegal = dec.funct3 == 3'b010 || dec.funct3 == 3'b011;
            end
            default: begin
                illegal = 1'b0;
            end
        endcase
    end

    // Only 4-byte alignment is legal here
    assign misaligned = target[1];

    assign cmp_eq  = rs1_data == rs2_data;
    assign cmp_lt  = $signed(rs1_data) < $signed(rs2_data);
    assign cmp_ltu = rs1_data < rs2_data;

    always_comb begin
        if (dec.opcode == BRANCH) begin
            case (dec.funct3)
                3'b000:  cond_taken = cmp_eq;   // BEQ
                3'b001:  cond_taken = !cmp_eq;  // BNE
                3'b100:  cond_taken = cmp_lt;   // BLT
                3'b101:  cond_taken = !cmp_lt;  // BGE
                3'b110:  cond_taken = cmp_ltu;  // BLTU
                3'b111:  cond_taken = !cmp_ltu; // BGEU
                default: cond_taken = 1'b0;
            endcase
        end else begin
            cond_taken = 1'b1; // Jumps always go
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            result.exception  <= illegal || misaligned;
            result.trap_cause <= illegal ? EXC_ILLEGAL_INSTR : EXC_INSTR_ADDR_MISALIGNED;
            result.rd         <= dec.rd;
            result.wr_en      <= dec.opcode != BRANCH && dec.rd != 5'd0
                                 && !(illegal || misaligned);
            result.data       <= dec.next_pc; // Link value, not the target
        end
    end

    // Taken flag only moves on real request cycles
    always_ff @(posedge clk) begin
        if (rst) begin
            taken_q <= 1'b0;
        end else if (req_valid) begin
            taken_q <= fire && cond_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (fire && cond_taken) begin
            saved_target <= target;
        end
    end

    assign redirect.valid = req_valid && taken_q && saved_target != pc;
    assign redirect.pc    = saved_target;

endmodule

// File: verilog/exec_alu.sv
`timescale 1ns/1ps
`include "exec_settings.svh"

module exec_alu
    import exec_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  decoded_t          dec,
    input  logic [`XLEN-1:0]  rs1_data,
    input  logic [`XLEN-1:0]  rs2_data,
    input  logic              accept,
    output exec_result_t      result
);

    localparam int SHW = $clog2(`XLEN);

    logic [`XLEN-1:0] op_b;
    logic [SHW-1:0]   shamt;
    logic             do_sub;
    logic [`XLEN-1:0] alu_out;
    logic             fire;

    assign fire   = accept && (dec.is_alu || dec.is_illegal);
    assign op_b   = (dec.opcode == OP) ? rs2_data : dec.imm;
    assign shamt  = op_b[SHW-1:0];
    assign do_sub = dec.opcode == OP && dec.funct7_alt; // SUB has no immediate form

    always_comb begin
        if (dec.opcode == LUI) begin
            alu_out = dec.imm;
        end else begin
            case (dec.funct3)
                3'b000:  alu_out = do_sub ? rs1_data - op_b : rs1_data + op_b;
                3'b001:  alu_out = rs1_data << shamt;
                3'b010:  alu_out = `XLEN'($signed(rs1_data) < $signed(op_b));
                3'b011:  alu_out = `XLEN'(rs1_data < op_b);
                3'b100:  alu_out = rs1_data ^ op_b;
                3'b101: begin
                    if (dec.funct7_alt) begin
                        alu_out = $unsigned($signed(rs1_data) >>> shamt);
                    end else begin
                        alu_out = rs1_data >> shamt;
                    end
                end
                3'b110:  alu_out = rs1_data | op_b;
                default: alu_out = rs1_data & op_b;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            result.exception  <= dec.is_illegal;
            result.trap_cause <= EXC_ILLEGAL_INSTR; // Only cause this unit raises
            result.rd         <= dec.rd;
            result.wr_en      <= !dec.is_illegal && dec.rd != 5'd0;
            result.data       <= alu_out;
        end
    end

endmodule

// File: verilog/exec_stage.sv
`timescale 1ns/1ps

module exec_stage
    import exec_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  exec_in_t      req,
    output exec_result_t  result,
    output redirect_t     redirect
);

    decoded_t     dec;
    exec_result_t br_result;
    exec_result_t alu_result;
    logic         accept;

    // Request after a mispredict is dropped
    assign accept = req.valid && !redirect.valid;

    instr_decode i_decode (
        .instr (req.instr),
        .pc    (req.pc),
        .dec   (dec)
    );

    exec_branch i_branch (
        .clk       (clk),
        .rst       (rst),
        .dec       (dec),
        .pc        (req.pc),
        .rs1_data  (req.rs1_data),
        .rs2_data  (req.rs2_data),
        .req_valid (req.valid),
        .accept    (accept),
        .result    (br_result),
        .redirect  (redirect)
    );

    exec_alu i_alu (
        .clk      (clk),
        .rst      (rst),
        .dec      (dec),
        .rs1_data (req.rs1_data),
        .rs2_data (req.rs2_data),
        .accept   (accept),
        .result   (alu_result)
    );

    // One owner per instruction, so at most one valid
    assign result = br_result.valid ? br_result : alu_result;

endmodule

// File: test/exec_stage_tb.sv
`timescale 1ns/1ps
`include "exec_settings.svh"

module exec_stage_tb
    import exec_pkg::*;
;

    typedef struct {
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] rs1;
        logic [31:0] rs2;
        int          idle;   // Idle cycles before the request
        bit          follow; // Use the expected next pc instead of pc
    } entry_t;

    logic         clk;
    logic         rst;
    exec_in_t     req;
    exec_result_t result;
    redirect_t    redirect;

    entry_t       tbl[$];
    logic [31:0]  rng_state;
    int           mismatches;
    int           protocol_errors;
    int           cycles;
    int           cycle_limit;
    bit           m_taken;
    logic [31:0]  m_target;
    logic [31:0]  m_next;

    exec_stage i_dut (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .result   (result),
        .redirect (redirect)
    );

    always #10 clk = !clk;

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, the table did not finish", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd);
        return {f7, 5'd2, 5'd1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [2:0] f3, logic [4:0] rd,
                                          logic [6:0] op);
        return {imm, 5'd1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic add(logic [31:0] instr, logic [31:0] rs1, logic [31:0] rs2,
                       int idle = 0, bit follow = 1, logic [31:0] pc = 0);
        entry_t e;
        e.instr  = instr;
        e.pc     = pc;
        e.rs1    = rs1;
        e.rs2    = rs2;
        e.idle   = idle;
        e.follow = follow;
        tbl.push_back(e);
    endtask

    // Reference model of one instruction, from the ISA rules
    task automatic model_exec(input logic [31:0] w, input logic [31:0] pc,
                              input logic [31:0] a, input logic [31:0] rs2,
                              output exec_result_t res, output bit is_br,
                              output bit taken, output logic [31:0] target);
        logic [4:0]  op;
        logic [2:0]  f3;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        bit          ill;
        bit          ok;
        op    = w[6:2];
        f3    = w[14:12];
        ok    = w[1:0] == 2'b11;
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        is_br = ok && (op == 5'b11011 || op == 5'b11001 || op == 5'b11000);
        taken = 1'b0;
        target = '0;
        res.valid = 1'b1;
        res.rd = w[11:7];
        res.trap_cause = EXC_ILLEGAL_INSTR;
        if (is_br) begin
            ill = 1'b0;
            taken = 1'b1; // Jumps
            if (op == 5'b11011) begin
                target = pc + imm_j;
            end else if (op == 5'b11001) begin
                target = (a + imm_i) & ~32'd1;
                ill = f3 != 3'b000;
            end else begin
                target = pc + imm_b;
                ill = f3 == 3'b010 || f3 == 3'b011;
                case (f3)
                    3'b000:  taken = a == rs2;
                    3'b001:  taken = a != rs2;
                    3'b100:  taken = $signed(a) < $signed(rs2);
                    3'b101:  taken = $signed(a) >= $signed(rs2);
                    3'b110:  taken = a < rs2;
                    3'b111:  taken = a >= rs2;
                    default: taken = 1'b0;
                endcase
            end
            res.exception = ill || target[1];
            res.trap_cause = ill ? EXC_ILLEGAL_INSTR : EXC_INSTR_ADDR_MISALIGNED;
            res.wr_en = op != 5'b11000 && res.rd != 0 && !res.exception;
            res.data = pc + 4;
        end else if (ok && (op == 5'b01100 || op == 5'b00100 || op == 5'b01101)) begin
            b = (op == 5'b01100) ? rs2 : imm_i;
            case (f3)
                3'b000:  res.data = (op == 5'b01100 && w[30]) ? a - b : a + b;
                3'b001:  res.data = a << b[4:0];
                3'b010:  res.data = {31'd0, $signed(a) < $signed(b)};
                3'b011:  res.data = {31'd0, a < b};
                3'b100:  res.data = a ^ b;
                3'b101:  res.data = w[30] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
                3'b110:  res.data = a | b;
                default: res.data = a & b;
            endcase
            if (op == 5'b01101) res.data = {w[31:12], 12'b0};
            res.exception = 1'b0;
            res.wr_en = res.rd != 0;
        end else begin
            res.exception = 1'b1;
            res.wr_en = 1'b0;
            res.data = '0;
        end
    endtask

    task automatic check_field(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_result(exec_result_t got, exec_result_t exp);
        if (got.valid !== exp.valid) begin
            if (exp.valid) $display("At %0t a result was expected but none came", $time);
            else $display("At %0t a result came where none was expected", $time);
            protocol_errors++;
        end else if (exp.valid) begin
            check_field("result.exception", got.exception, exp.exception);
            if (exp.exception) check_field("result.trap_cause", got.trap_cause, exp.trap_cause);
            check_field("result.rd", got.rd, exp.rd);
            check_field("result.wr_en", got.wr_en, exp.wr_en);
            if (!exp.exception) check_field("result.data", got.data, exp.data);
        end
    endtask

    task automatic check_redirect(redirect_t got, redirect_t exp);
        check_field("redirect.valid", got.valid, exp.valid);
        if (exp.valid && got.valid === 1'b1) check_field("redirect.pc", got.pc, exp.pc);
    endtask

    // Drives one cycle at edge plus 2 ns and checks it
    task automatic run_cycle(bit v, entry_t e);
        exec_result_t exp_res;
        redirect_t    exp_redir;
        bit           is_br;
        bit           taken;
        logic [31:0]  target;
        logic [31:0]  pc;
        pc = e.follow ? m_next : e.pc;
        req.valid    = v;
        req.instr    = e.instr;
        req.pc       = pc;
        req.rs1_data = e.rs1;
        req.rs2_data = e.rs2;
        model_exec(e.instr, pc, e.rs1, e.rs2, exp_res, is_br, taken, target);
        exp_redir.valid = v && m_taken && m_target != pc;
        exp_redir.pc = m_target;
        exp_res.valid = v && !exp_redir.valid;
        if (v) begin
            if (exp_redir.valid) m_next = m_target;
            else m_next = (is_br && taken) ? target : pc + 4;
            m_taken = exp_res.valid && is_br && taken;
            if (m_taken) m_target = target;
        end
        #8;
        check_redirect(redirect, exp_redir);
        @(posedge clk);
        #1;
        check_result(result, exp_res);
        #1;
    endtask

    initial begin
        entry_t       idle_e;
        exec_result_t no_res;
        logic [31:0]  pairs[5][2];
        logic [2:0]   bf3[6];
        clk = 0;
        rst = 1;
        req = '0;
        rng_state = 89;
        mismatches = 0;
        protocol_errors = 0;
        cycles = 0;
        cycle_limit = 0;
        m_taken = 0;
        m_target = '0;
        m_next = 32'h100;
        idle_e = '{default: '0};
        no_res = '0;
        pairs = '{'{5, 5}, '{3, 7}, '{7, 3}, '{-2, 3}, '{3, -2}};
        bf3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

        add(enc_i(12'd5, 3'b000, 5'd1, 7'b0010011), 32'd10, 0);
        for (int f = 0; f < 8; f++) begin
            add(enc_r(7'd0, f[2:0], 5'd3), xorshift(), xorshift());
        end
        add(enc_r(7'h20, 3'b000, 5'd3), xorshift(), xorshift()); // SUB
        add(enc_r(7'h20, 3'b101, 5'd3), 32'h8000_0f00, 32'd4);   // SRA
        add(enc_i(12'hff6, 3'b010, 5'd4, 7'b0010011), 32'hffff_fff0, 0); // SLTI
        add(enc_i(12'h403, 3'b101, 5'd4, 7'b0010011), 32'h9000_0000, 0); // SRAI
        add({20'habcde, 5'd7, 7'b0110111}, 0, 0);                        // LUI
        add(enc_r(7'd0, 3'b000, 5'd0), xorshift(), xorshift());          // rd zero
        for (int f = 0; f < 6; f++) begin
            for (int p = 0; p < 5; p++) begin
                add(enc_b(13'd16, bf3[f]), pairs[p][0], pairs[p][1]);
            end
        end
        add(enc_j(21'h40, 5'd1), 0, 0);
        add(enc_j(21'h8, 5'd0), 0, 0);
        add(enc_i(12'h010, 3'b000, 5'd1, 7'b1100111), 32'h401, 0);  // JALR bit 0
        add(enc_i(12'h000, 3'b001, 5'd1, 7'b1100111), 32'h500, 0);  // Bad funct3
        add(enc_b(13'd8, 3'b010), 1, 1);
        add(enc_b(13'd8, 3'b011), 1, 1);
        add(enc_j(21'h6, 5'd1), 0, 0);                              // Misaligned
        add(enc_j(21'h2, 5'd1), 0, 0);                              // Realigns
        add(32'h0000_000f, 0, 0);                                   // Unknown opcode
        add(enc_i(12'd1, 3'b000, 5'd1, 7'b0010001), 0, 0);          // Low bits 01
        add(enc_b(13'd32, 3'b000), 5, 5);
        add(enc_i(12'd1, 3'b000, 5'd1, 7'b0010011), 1, 0, 0, 0, 32'h900);
        add(enc_i(12'd2, 3'b000, 5'd1, 7'b0010011), 1, 0);
        add(enc_j(21'h20, 5'd1), 0, 0);
        add(enc_i(12'd1, 3'b000, 5'd1, 7'b0010011), 1, 0, 3, 0, 32'h700);
        add(enc_j(21'h20, 5'd1), 0, 0);
        add(enc_i(12'd3, 3'b000, 5'd1, 7'b0010011), 1, 0, 2);
        cycle_limit = tbl.size() * 4 + 50;

        // Taken jump held during reset
        req.valid = 1'b1;
        req.instr = enc_j(21'h0, 5'd1);
        req.pc    = 32'h40;

        repeat (8) @(posedge clk);
        #2;
        rst = 0;
        check_result(result, no_res);
        foreach (tbl[i]) begin
            repeat (tbl[i].idle) run_cycle(0, idle_e);
            run_cycle(1, tbl[i]);
        end
        run_cycle(0, idle_e);

        $display("Errors: %0d mismatches, %0d missing or extra results",
                 mismatches, protocol_errors);
        if (mismatches == 0 && protocol_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+include
verilog/exec_pkg.sv
verilog/instr_decode.sv
verilog/exec_branch.sv
verilog/exec_alu.sv
verilog/exec_stage.sv
test/exec_stage_tb.sv

// File: Bender.yml
package:
  name: exec_stage

export_include_dirs:
  - include

sources:
  - files:
      - verilog/exec_pkg.sv
      - verilog/instr_decode.sv
      - verilog/exec_branch.sv
      - verilog/exec_alu.sv
      - verilog/exec_stage.sv
  - target: test
    files:
      - test/exec_stage_tb.sv
